// ==== axi_regbank_settings.svh ====
`ifndef AXI_REGBANK_SETTINGS_SVH
`define AXI_REGBANK_SETTINGS_SVH

// AXI address width in bits, enough for 32 words of 4 bytes
`define REGBANK_ADDR_WIDTH 7

// data width of the bus and of every register
`define REGBANK_DATA_WIDTH 32

// number of registers in the bank
`define REGBANK_REG_COUNT 32

// lowest address bit that selects a register
`define REGBANK_ADDR_LSB 2

`endif

// ==== axi_lite_pkg.sv ====
`default_nettype none

`include "axi_regbank_settings.svh"

package axi_lite_pkg;

  typedef logic [`REGBANK_ADDR_WIDTH-1:0] addr_t;        // byte address on the bus
  typedef logic [`REGBANK_DATA_WIDTH-1:0] data_t;
  typedef logic [`REGBANK_DATA_WIDTH/8-1:0] strb_t;      // one strobe per byte lane

  // AXI response codes, the bank only ever answers okay
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_t;

endpackage

`default_nettype wire

// ==== regbank_pkg.sv ====
`default_nettype none

`include "axi_regbank_settings.svh"

package regbank_pkg;

  // word index, taken from the address bits above the byte offset
  typedef logic [$clog2(`REGBANK_REG_COUNT)-1:0] reg_index_t;

  typedef enum logic [1:0] {
    wr_idle   = 2'b00,  // waiting for both address and data
    wr_accept = 2'b01,  // ready pulse and register write
    wr_resp   = 2'b10   // response held until bready
  } wr_state_t;

  typedef enum logic [1:0] {
    rd_idle   = 2'b00,
    rd_accept = 2'b01,  // arready pulse, register selected
    rd_data   = 2'b10   // read data held until rready
  } rd_state_t;

endpackage

`default_nettype wire

// ==== reg_write_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface reg_write_if
  import axi_lite_pkg::*, regbank_pkg::*;
  ;

  logic       wr_en;     // single cycle commit strobe
  reg_index_t wr_index;
  data_t      wr_data;
  strb_t      wr_strb;

  // the write channel drives the request
  modport source (
    output wr_en,
    output wr_index,
    output wr_data,
    output wr_strb
  );

  // the register file commits it at the next edge, never stalls
  modport sink (
    input wr_en,
    input wr_index,
    input wr_data,
    input wr_strb
  );

endinterface

`default_nettype wire

// ==== axi_write_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_regbank_settings.svh"

module axi_write_channel
  import axi_lite_pkg::*, regbank_pkg::*;
(
  input  logic        S_AXI_ACLK,
  input  logic        S_AXI_ARESETN,
  input  addr_t       awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  data_t       wdata,
  input  strb_t       wstrb,
  input  logic        wvalid,
  output logic        wready,
  output resp_t       bresp,
  output logic        bvalid,
  input  logic        bready,
  reg_write_if.source wr
);

  wr_state_t wr_state;
  logic      awready_q;
  logic      wready_q;
  logic      bvalid_q;
  logic      both_valid;
  addr_t     awaddr_q;
  data_t     wdata_q;
  strb_t     wstrb_q;

  assign both_valid = awvalid && wvalid;  // address and data may arrive in any order

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_state  <= wr_idle;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (both_valid) begin
            wr_state  <= wr_accept;
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
          end
        end
        wr_accept: begin
          wr_state  <= wr_resp;  // register is written at this edge
          awready_q <= 1'b0;
          wready_q  <= 1'b0;
          bvalid_q  <= 1'b1;
        end
        wr_resp: begin
          if (bready) begin
            wr_state <= wr_idle;
            bvalid_q <= 1'b0;
          end
        end
        default: begin
          wr_state  <= wr_idle;
          awready_q <= 1'b0;
          wready_q  <= 1'b0;
          bvalid_q  <= 1'b0;
        end
      endcase
    end
  end

  // request payload, only loaded when idle so it stays put through the accept cycle
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_state == wr_idle && both_valid) begin
      awaddr_q <= awaddr;
      wdata_q  <= wdata;
      wstrb_q  <= wstrb;
    end
  end

  assign awready = awready_q;
  assign wready  = wready_q;
  assign bvalid  = bvalid_q;
  assign bresp   = okay;

  assign wr.wr_en    = (wr_state == wr_accept);
  assign wr.wr_index = awaddr_q[`REGBANK_ADDR_LSB +: $bits(reg_index_t)];
  assign wr.wr_data  = wdata_q;
  assign wr.wr_strb  = wstrb_q;

  // both readies pulse together with the register write, and the response follows
  a_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (awready || wready) |-> (awready && wready && wr.wr_en) ##1
      (!awready && !wready && bvalid));

  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (bvalid && !bready) |=> bvalid);

endmodule

`default_nettype wire

// ==== axi_read_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_regbank_settings.svh"

module axi_read_channel
  import axi_lite_pkg::*, regbank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  addr_t      araddr,
  input  logic       arvalid,
  output logic       arready,
  output data_t      rdata,
  output resp_t      rresp,
  output logic       rvalid,
  input  logic       rready,
  output reg_index_t rd_index,
  input  data_t      rd_data
);

  rd_state_t rd_state;
  logic      arready_q;
  logic      rvalid_q;
  data_t     rdata_q;
  addr_t     araddr_q;

  // the port rd_data hides the state literal of the same name, so it is named in full
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rd_state  <= rd_idle;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (arvalid) begin
            rd_state  <= rd_accept;
            arready_q <= 1'b1;
          end
        end
        rd_accept: begin
          rd_state  <= regbank_pkg::rd_data;
          arready_q <= 1'b0;
          rvalid_q  <= 1'b1;
          rdata_q   <= rd_data;  // value before any write committed at this edge
        end
        regbank_pkg::rd_data: begin
          if (rready) begin
            rd_state <= rd_idle;
            rvalid_q <= 1'b0;
          end
        end
        default: begin
          rd_state  <= rd_idle;
          arready_q <= 1'b0;
          rvalid_q  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_state == rd_idle && arvalid) begin
      araddr_q <= araddr;
    end
  end

  assign rd_index = araddr_q[`REGBANK_ADDR_LSB +: $bits(reg_index_t)];
  assign arready  = arready_q;
  assign rvalid   = rvalid_q;
  assign rdata    = rdata_q;
  assign rresp    = okay;

  // data must not move while the master stalls
  a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_regbank_settings.svh"

module reg_file
  import axi_lite_pkg::*, regbank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  reg_write_if.sink  wr,
  input  reg_index_t rd_index,
  output data_t      rd_data
);

  data_t regs [`REGBANK_REG_COUNT];

  // replaces only the byte lanes whose strobe is set
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < `REGBANK_DATA_WIDTH/8; b++) begin
      if (strb[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < `REGBANK_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wr_en) begin
      regs[wr.wr_index] <= merge_bytes(regs[wr.wr_index], wr.wr_data, wr.wr_strb);
    end
  end

  assign rd_data = regs[rd_index];  // plain mux, sees the contents before this cycle's write

endmodule

`default_nettype wire

// ==== axi_regbank.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_regbank
  import axi_lite_pkg::*, regbank_pkg::*;
(
  input  logic  S_AXI_ACLK,
  input  logic  S_AXI_ARESETN,
  input  addr_t S_AXI_AWADDR,
  input  logic  S_AXI_AWVALID,
  output logic  S_AXI_AWREADY,
  input  data_t S_AXI_WDATA,
  input  strb_t S_AXI_WSTRB,
  input  logic  S_AXI_WVALID,
  output logic  S_AXI_WREADY,
  output resp_t S_AXI_BRESP,
  output logic  S_AXI_BVALID,
  input  logic  S_AXI_BREADY,
  input  addr_t S_AXI_ARADDR,
  input  logic  S_AXI_ARVALID,
  output logic  S_AXI_ARREADY,
  output data_t S_AXI_RDATA,
  output resp_t S_AXI_RRESP,
  output logic  S_AXI_RVALID,
  input  logic  S_AXI_RREADY
);

  reg_index_t rd_index;
  data_t      rd_word;  // selected register, back to the read channel

  reg_write_if wr_if ();

  axi_write_channel i_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr            (wr_if.source)
  );

  axi_read_channel i_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_index      (rd_index),
    .rd_data       (rd_word)
  );

  reg_file i_reg_file (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (wr_if.sink),
    .rd_index      (rd_index),
    .rd_data       (rd_word)
  );

endmodule

`default_nettype wire

// ==== tb_axi_regbank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_regbank_settings.svh"

module tb_axi_regbank
  import axi_lite_pkg::*, regbank_pkg::*;
;

  localparam int max_cycles = 20000;  // the directed tests need about 3000 cycles

  logic  S_AXI_ACLK;
  logic  S_AXI_ARESETN;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  data_t  model [`REGBANK_REG_COUNT];  // expected contents of the bank
  integer seed;
  int     cycle_count = 0;

  axi_regbank i_dut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready)
  );

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  always @(posedge S_AXI_ACLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic compare_resp(input string name, input resp_t expected, input resp_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected resp %h, actual resp %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
      stop_on_error();
    end
  endtask

  function automatic addr_t to_addr(input reg_index_t index);
    return {index, 2'b00};  // word aligned byte address
  endfunction

  function automatic void model_write(input reg_index_t index, input data_t data,
                                      input strb_t strb);
    data_t mask;
    mask = '0;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) mask = mask | (data_t'(8'hff) << (8 * b));
    end
    model[index] = (model[index] & ~mask) | (data & mask);
  endfunction

  // waits for the ready pulse, then for the response, which bready decides when to take
  task automatic complete_write(input string name);
    @(negedge S_AXI_ACLK);
    while (!awready) @(negedge S_AXI_ACLK);
    compare_flag({name, " wready"}, 1'b1, wready);
    @(posedge S_AXI_ACLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!(bvalid && bready)) @(negedge S_AXI_ACLK);
    compare_resp({name, " bresp"}, okay, bresp);
    @(posedge S_AXI_ACLK);
    bready <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag({name, " single response"}, 1'b0, bvalid);
    compare_flag({name, " no new accept"}, 1'b0, awready);
  endtask

  task automatic write_word(input string name, input reg_index_t index, input data_t data,
                            input strb_t strb);
    @(posedge S_AXI_ACLK);
    awaddr  <= to_addr(index);
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    complete_write(name);
    model_write(index, data, strb);
  endtask

  task automatic read_word(input string name, input reg_index_t index, output data_t data);
    @(posedge S_AXI_ACLK);
    araddr  <= to_addr(index);
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(negedge S_AXI_ACLK);
    while (!arready) @(negedge S_AXI_ACLK);
    @(posedge S_AXI_ACLK);
    arvalid <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!rvalid) @(negedge S_AXI_ACLK);
    compare_resp({name, " rresp"}, okay, rresp);
    data = rdata;
    @(posedge S_AXI_ACLK);
    rready <= 1'b0;
  endtask

  task automatic check_read(input string name, input reg_index_t index);
    data_t got;
    read_word(name, index, got);
    compare_data(name, model[index], got);
  endtask

  task automatic test_reset_state();
    data_t got;
    @(negedge S_AXI_ACLK);
    compare_flag("reset awready", 1'b0, awready);
    compare_flag("reset wready", 1'b0, wready);
    compare_flag("reset bvalid", 1'b0, bvalid);
    compare_flag("reset arready", 1'b0, arready);
    compare_flag("reset rvalid", 1'b0, rvalid);
    compare_data("reset rdata", '0, rdata);
    for (int i = 0; i < `REGBANK_REG_COUNT; i++) begin
      read_word("reset readback", reg_index_t'(i), got);
      compare_data("reset readback", '0, got);
    end
  endtask

  task automatic test_word_write();
    reg_index_t index;
    index = 5'd9;
    @(posedge S_AXI_ACLK);
    awaddr  <= to_addr(index);
    awvalid <= 1'b1;
    wdata   <= 32'hdead_beef;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(negedge S_AXI_ACLK);
    compare_flag("word write awready before edge 0", 1'b0, awready);
    @(negedge S_AXI_ACLK);
    compare_flag("word write awready", 1'b1, awready);
    compare_flag("word write wready", 1'b1, wready);
    compare_flag("word write bvalid early", 1'b0, bvalid);
    @(posedge S_AXI_ACLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag("word write awready pulse", 1'b0, awready);
    compare_flag("word write wready pulse", 1'b0, wready);
    compare_flag("word write bvalid", 1'b1, bvalid);
    compare_resp("word write bresp", okay, bresp);
    @(posedge S_AXI_ACLK);
    bready <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag("word write bvalid falls", 1'b0, bvalid);
    model_write(index, 32'hdead_beef, 4'hf);
    @(posedge S_AXI_ACLK);
    araddr  <= to_addr(index);
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(negedge S_AXI_ACLK);
    compare_flag("word read arready before edge 0", 1'b0, arready);
    @(negedge S_AXI_ACLK);
    compare_flag("word read arready", 1'b1, arready);
    compare_flag("word read rvalid early", 1'b0, rvalid);
    @(posedge S_AXI_ACLK);
    arvalid <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag("word read arready pulse", 1'b0, arready);
    compare_flag("word read rvalid", 1'b1, rvalid);
    compare_resp("word read rresp", okay, rresp);
    compare_data("word read rdata", model[index], rdata);
    @(posedge S_AXI_ACLK);
    rready <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag("word read rvalid falls", 1'b0, rvalid);
  endtask

  task automatic test_byte_strobes();
    for (int s = 0; s < 16; s++) begin  // every strobe pattern over a known word
      write_word("byte strobes base", 5'd12, 32'h1122_3344, 4'hf);
      write_word("byte strobes merge", 5'd12, 32'haabb_ccdd, strb_t'(s));
      check_read("byte strobes readback", 5'd12);
    end
  endtask

  task automatic test_split_write(input string name, input logic addr_first,
                                  input reg_index_t index, input data_t data);
    @(posedge S_AXI_ACLK);
    awaddr <= to_addr(index);
    wdata  <= data;
    wstrb  <= 4'hf;
    bready <= 1'b1;
    if (addr_first) awvalid <= 1'b1;
    else wvalid <= 1'b1;
    repeat (6) begin
      @(negedge S_AXI_ACLK);
      compare_flag({name, " awready"}, 1'b0, awready);
      compare_flag({name, " wready"}, 1'b0, wready);
      compare_flag({name, " bvalid"}, 1'b0, bvalid);
    end
    check_read({name, " not landed"}, index);  // model still holds the old word
    @(posedge S_AXI_ACLK);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    complete_write(name);
    model_write(index, data, 4'hf);
    check_read({name, " readback"}, index);
  endtask

  task automatic test_back_pressure();
    data_t held;
    @(posedge S_AXI_ACLK);
    awaddr  <= to_addr(5'd3);
    awvalid <= 1'b1;
    wdata   <= 32'h0123_4567;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!awready) @(negedge S_AXI_ACLK);
    @(posedge S_AXI_ACLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!bvalid) @(negedge S_AXI_ACLK);
    model_write(5'd3, 32'h0123_4567, 4'hf);
    @(posedge S_AXI_ACLK);
    awaddr  <= to_addr(5'd4);  // second write waits behind the pending response
    awvalid <= 1'b1;
    wdata   <= 32'h89ab_cdef;
    wvalid  <= 1'b1;
    repeat (10) begin
      @(negedge S_AXI_ACLK);
      compare_flag("back pressure bvalid held", 1'b1, bvalid);
      compare_flag("back pressure second write blocked", 1'b0, awready);
    end
    @(posedge S_AXI_ACLK);
    bready <= 1'b1;
    complete_write("back pressure second write");
    model_write(5'd4, 32'h89ab_cdef, 4'hf);
    check_read("back pressure first word", 5'd3);
    check_read("back pressure second word", 5'd4);
    @(posedge S_AXI_ACLK);
    araddr  <= to_addr(5'd4);
    arvalid <= 1'b1;
    rready  <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!arready) @(negedge S_AXI_ACLK);
    @(posedge S_AXI_ACLK);
    arvalid <= 1'b0;
    @(negedge S_AXI_ACLK);
    while (!rvalid) @(negedge S_AXI_ACLK);
    held = rdata;
    compare_data("read back pressure data", model[4], held);
    @(posedge S_AXI_ACLK);
    araddr <= to_addr(5'd3);  // the held data must not follow the address bus or the register
    write_word("read back pressure rewrite", 5'd4, 32'h7654_3210, 4'hf);
    repeat (10) begin
      @(negedge S_AXI_ACLK);
      compare_flag("read back pressure rvalid held", 1'b1, rvalid);
      compare_data("read back pressure rdata stable", held, rdata);
    end
    @(posedge S_AXI_ACLK);
    rready <= 1'b1;
    @(posedge S_AXI_ACLK);
    rready <= 1'b0;
    @(negedge S_AXI_ACLK);
    compare_flag("read back pressure rvalid falls", 1'b0, rvalid);
    check_read("read back pressure rewrite readback", 5'd4);
  endtask

  task automatic test_random_traffic();
    reg_index_t index;
    data_t      data;
    strb_t      strb;
    for (int n = 0; n < 64; n++) begin
      index = reg_index_t'($random(seed));
      data  = data_t'($random(seed));
      strb  = strb_t'($random(seed));
      write_word("random write", index, data, strb);
    end
    for (int i = 0; i < `REGBANK_REG_COUNT; i++) begin
      check_read("random readback", reg_index_t'(i));
    end
  endtask

  initial begin
    seed          = 32'h4c62_30e1;
    S_AXI_ARESETN = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    for (int i = 0; i < `REGBANK_REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (3) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    test_reset_state();
    test_word_write();
    test_byte_strobes();
    test_split_write("split address first", 1'b1, 5'd17, 32'h0bad_f00d);
    test_split_write("split data first", 1'b0, 5'd18, 32'h600d_cafe);
    test_back_pressure();
    test_random_traffic();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_regbank.f ====
+incdir+.
axi_lite_pkg.sv
regbank_pkg.sv
reg_write_if.sv
axi_write_channel.sv
axi_read_channel.sv
reg_file.sv
axi_regbank.sv
tb_axi_regbank.sv
